// File: design/video_pkg.sv
`default_nettype none

package video_pkg;

	//////////////////////////////////////////////////////////////////////
	// beat payload

	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} pixel_t;

	// start-of-packet beat carries the packet type in the low nibble
	typedef struct packed {
		logic [19:0] reserved;
		logic [3:0]  packet_type;
	} pkt_desc_t;

	typedef union packed {
		pixel_t    pix;   // ordinary beats
		pkt_desc_t desc;  // sop beat
	} beat_word_u;

	typedef struct packed {
		beat_word_u data;
		logic       sop;
		logic       eop;
	} stream_beat_t;

	//////////////////////////////////////////////////////////////////////
	// classification and geometry

	typedef enum logic [1:0] {NONE, RED, GREEN, BLUE} colour_e;

	typedef logic [10:0] coord_t;

	typedef struct packed {
		logic   valid;
		coord_t left;
		coord_t right;
	} box_t;

	typedef box_t [BLUE:RED] box_set_t;  // indexed by colour

	localparam logic [3:0] VIDEO_PKT_TYPE = 4'h0;

	localparam pixel_t HIGHLIGHT_RED   = 24'hff0000;
	localparam pixel_t HIGHLIGHT_GREEN = 24'h00ff00;
	localparam pixel_t HIGHLIGHT_BLUE  = 24'h0000ff;

endpackage

`default_nettype wire

// File: design/regs_pkg.sv
`default_nettype none

package regs_pkg;

	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [7:0]  paddr;
		logic [31:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [31:0] prdata;
		logic        pready;
		logic        pslverr;
	} apb_rsp_t;

	// register map
	localparam logic [7:0] ADDR_CTRL      = 8'h00;
	localparam logic [7:0] ADDR_STATUS    = 8'h04;  // read only
	localparam logic [7:0] ADDR_ID        = 8'h08;  // read only
	localparam logic [7:0] ADDR_COL_RED   = 8'h0C;
	localparam logic [7:0] ADDR_COL_GREEN = 8'h10;
	localparam logic [7:0] ADDR_COL_BLUE  = 8'h14;
	localparam logic [7:0] ADDR_BOX_RED   = 8'h18;  // box readback, read only
	localparam logic [7:0] ADDR_BOX_GREEN = 8'h1C;
	localparam logic [7:0] ADDR_BOX_BLUE  = 8'h20;

	localparam logic [31:0] IP_ID = 32'h1234EEE2;

	localparam logic [23:0] BOX_COL_RED_DEF   = 24'hFF0000;
	localparam logic [23:0] BOX_COL_GREEN_DEF = 24'h00FF00;
	localparam logic [23:0] BOX_COL_BLUE_DEF  = 24'h0000FF;

endpackage

`default_nettype wire

// File: design/stream_reg.sv
`default_nettype none

module stream_reg
	import video_pkg::*;
(
	input  logic         clk,
	input  logic         reset_n,
	input  logic         valid_i,
	input  stream_beat_t data_i,
	output logic         ready_o,
	output logic         valid_o,
	output stream_beat_t data_o,
	input  logic         ready_i
);

	// take a new beat when empty or when the held one leaves this cycle
	assign ready_o = ~valid_o | ready_i;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			valid_o <= 1'b0;
		end else if (ready_o) begin
			valid_o <= valid_i;
		end
	end

	always_ff @(posedge clk) begin
		if (ready_o) begin
			data_o <= data_i;
		end
	end

endmodule

`default_nettype wire

// File: design/frame_tracker.sv
`default_nettype none

module frame_tracker
	import video_pkg::*;
#(
	parameter int IMAGE_W = 640
) (
	input  logic         clk,
	input  logic         reset_n,
	input  logic         fire_i,
	input  stream_beat_t beat_i,
	output coord_t       pixel_x_o,
	output logic         is_video_o
);

	// pixel_x_o is the column of the beat currently waiting to fire
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			pixel_x_o  <= '0;
			is_video_o <= 1'b0;
		end else if (fire_i) begin
			if (beat_i.sop) begin
				pixel_x_o  <= '0;
				is_video_o <= (beat_i.data.desc.packet_type == VIDEO_PKT_TYPE);
			end else if (pixel_x_o == coord_t'(IMAGE_W - 1)) begin
				pixel_x_o <= '0;  // next line
			end else begin
				pixel_x_o <= pixel_x_o + 11'd1;
			end
		end
	end

endmodule

`default_nettype wire

// File: design/colour_classifier.sv
`default_nettype none

module colour_classifier
	import video_pkg::*;
#(
	parameter int RUN_LEN = 5
) (
	input  logic         clk,
	input  logic         reset_n,
	input  logic         fire_i,
	input  stream_beat_t beat_i,
	output colour_e      colour_o
);

	logic [8:0]               r, g, b;  // widened so +offset cannot wrap
	colour_e                  raw;
	colour_e [RUN_LEN-1:0]    hist;     // [0] is the most recent pixel
	logic                     run_ok;

	assign r = {1'b0, beat_i.data.pix.red};
	assign g = {1'b0, beat_i.data.pix.green};
	assign b = {1'b0, beat_i.data.pix.blue};

	//////////////////////////////////////////////////////////////////////
	// raw per-pixel rules, first match wins

	always_comb begin
		if (r > g + 9'd30 && r > b + 9'd30) begin
			raw = RED;
		end else if (g > b + 9'd10 && g > r + 9'd30) begin
			raw = GREEN;
		end else if (b + 9'd20 > g && b > r) begin
			raw = BLUE;
		end else begin
			raw = NONE;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// run filter

	always_comb begin
		run_ok = 1'b1;
		for (int i = 0; i < RUN_LEN; i++) begin
			if (hist[i] != raw) run_ok = 1'b0;
		end
	end

	assign colour_o = run_ok ? raw : NONE;  // NONE stays NONE either way

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			for (int i = 0; i < RUN_LEN; i++) hist[i] <= NONE;
		end else if (fire_i) begin
			if (beat_i.sop) begin
				for (int i = 0; i < RUN_LEN; i++) hist[i] <= NONE;  // new packet
			end else begin
				hist[0] <= raw;
				for (int i = 1; i < RUN_LEN; i++) hist[i] <= hist[i-1];
			end
		end
	end

endmodule

`default_nettype wire

// File: design/box_tracker.sv
`default_nettype none

module box_tracker
	import video_pkg::*;
#(
	parameter int IMAGE_W = 640
) (
	input  logic         clk,
	input  logic         reset_n,
	input  logic         fire_i,
	input  stream_beat_t beat_i,
	input  coord_t       pixel_x_i,
	input  logic         is_video_i,
	input  colour_e      colour_i,
	output box_set_t     boxes_o,
	output logic         frame_done_o
);

	localparam coord_t X_LAST = coord_t'(IMAGE_W - 1);

	coord_t [BLUE:RED] run_min, run_max;
	coord_t [BLUE:RED] min_nxt, max_nxt;
	logic   [BLUE:RED] run_hit, hit_nxt, match;

	// running values including the current beat, so the eop pixel counts
	always_comb begin
		for (int c = RED; c <= BLUE; c++) begin
			match[c]   = !beat_i.sop && (colour_i == colour_e'(c));
			min_nxt[c] = (match[c] && pixel_x_i < run_min[c]) ? pixel_x_i : run_min[c];
			max_nxt[c] = (match[c] && pixel_x_i > run_max[c]) ? pixel_x_i : run_max[c];
			hit_nxt[c] = run_hit[c] | match[c];
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			boxes_o      <= '0;
			frame_done_o <= 1'b0;
			run_hit      <= '0;
			for (int c = RED; c <= BLUE; c++) begin
				run_min[c] <= X_LAST;
				run_max[c] <= '0;
			end
		end else begin
			frame_done_o <= 1'b0;
			if (fire_i) begin
				if (beat_i.sop || (beat_i.eop && is_video_i)) begin
					run_hit <= '0;
					for (int c = RED; c <= BLUE; c++) begin
						run_min[c] <= X_LAST;
						run_max[c] <= '0;
					end
				end else begin
					run_min <= min_nxt;
					run_max <= max_nxt;
					run_hit <= hit_nxt;
				end
				if (!beat_i.sop && beat_i.eop && is_video_i) begin  // end of video frame
					frame_done_o <= 1'b1;
					for (int c = RED; c <= BLUE; c++) begin
						boxes_o[c] <= '{valid: hit_nxt[c], left: min_nxt[c], right: max_nxt[c]};
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: design/overlay_mixer.sv
`default_nettype none

module overlay_mixer
	import video_pkg::*;
(
	input  stream_beat_t      beat_i,
	input  coord_t            pixel_x_i,
	input  logic              is_video_i,
	input  colour_e           colour_i,
	input  box_set_t          boxes_i,
	input  logic              overlay_en_i,
	input  pixel_t [BLUE:RED] box_col_i,
	output stream_beat_t      beat_o
);

	pixel_t     pix;
	pixel_t     new_pix;
	logic [7:0] grey;
	colour_e    box_sel;

	assign pix  = beat_i.data.pix;
	assign grey = {1'b0, pix.green[7:1]} + {2'b0, pix.red[7:2]} + {2'b0, pix.blue[7:2]};

	always_comb begin
		box_sel = NONE;
		for (int c = BLUE; c >= RED; c--) begin  // walk down so red wins a tie
			if (boxes_i[c].valid && (boxes_i[c].left == pixel_x_i || boxes_i[c].right == pixel_x_i))
				box_sel = colour_e'(c);
		end

		if (box_sel != NONE) new_pix = box_col_i[box_sel];  // box column
		else begin
			case (colour_i)
				RED:     new_pix = HIGHLIGHT_RED;
				GREEN:   new_pix = HIGHLIGHT_GREEN;
				BLUE:    new_pix = HIGHLIGHT_BLUE;
				default: new_pix = '{red: grey, green: grey, blue: grey};
			endcase
		end

		beat_o = beat_i;
		if (overlay_en_i && !beat_i.sop && is_video_i) beat_o.data.pix = new_pix;  // descriptors untouched
	end

endmodule

`default_nettype wire

// File: design/apb_regs.sv
`default_nettype none

module apb_regs
	import video_pkg::*, regs_pkg::*;
(
	input  logic              clk,
	input  logic              reset_n,
	input  apb_req_t          apb_req_i,
	output apb_rsp_t          apb_rsp_o,
	input  box_set_t          boxes_i,
	input  logic              frame_done_i,
	output logic              overlay_en_o,
	output pixel_t [BLUE:RED] box_col_o
);

	logic        access, known, read_only, slverr, wr_ok;
	logic [31:0] rdata;
	logic [15:0] frame_cnt;

	function automatic logic [31:0] box_word(box_t bx);
		return {bx.valid, 4'b0, bx.left, 5'b0, bx.right};
	endfunction

	assign access = apb_req_i.psel & apb_req_i.penable;

	//////////////////////////////////////////////////////////////////////
	// address decode and read mux

	always_comb begin
		rdata     = '0;
		known     = 1'b1;
		read_only = 1'b0;
		case (apb_req_i.paddr)
			ADDR_CTRL:      rdata = {31'b0, overlay_en_o};
			ADDR_STATUS:    begin rdata = {16'b0, frame_cnt}; read_only = 1'b1; end
			ADDR_ID:        begin rdata = IP_ID; read_only = 1'b1; end
			ADDR_COL_RED:   rdata = {8'b0, box_col_o[RED]};
			ADDR_COL_GREEN: rdata = {8'b0, box_col_o[GREEN]};
			ADDR_COL_BLUE:  rdata = {8'b0, box_col_o[BLUE]};
			ADDR_BOX_RED:   begin rdata = box_word(boxes_i[RED]); read_only = 1'b1; end
			ADDR_BOX_GREEN: begin rdata = box_word(boxes_i[GREEN]); read_only = 1'b1; end
			ADDR_BOX_BLUE:  begin rdata = box_word(boxes_i[BLUE]); read_only = 1'b1; end
			default:        known = 1'b0;
		endcase
	end

	assign slverr    = access & (~known | (apb_req_i.pwrite & read_only));
	assign wr_ok     = access & apb_req_i.pwrite & ~slverr;
	assign apb_rsp_o = '{prdata: rdata, pready: 1'b1, pslverr: slverr};  // no wait states

	//////////////////////////////////////////////////////////////////////
	// writable state and frame counter

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			overlay_en_o     <= 1'b0;
			box_col_o[RED]   <= BOX_COL_RED_DEF;
			box_col_o[GREEN] <= BOX_COL_GREEN_DEF;
			box_col_o[BLUE]  <= BOX_COL_BLUE_DEF;
			frame_cnt        <= '0;
		end else begin
			if (frame_done_i) frame_cnt <= frame_cnt + 16'd1;
			if (wr_ok) begin
				case (apb_req_i.paddr)
					ADDR_CTRL:      overlay_en_o     <= apb_req_i.pwdata[0];
					ADDR_COL_RED:   box_col_o[RED]   <= apb_req_i.pwdata[23:0];
					ADDR_COL_GREEN: box_col_o[GREEN] <= apb_req_i.pwdata[23:0];
					ADDR_COL_BLUE:  box_col_o[BLUE]  <= apb_req_i.pwdata[23:0];
					default:        ;  // read-only offsets never reach here
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: design/imgproc_top.sv
`default_nettype none

module imgproc_top
	import video_pkg::*, regs_pkg::*;
#(
	parameter int IMAGE_W = 640,
	parameter int RUN_LEN = 5
) (
	input  logic         clk,
	input  logic         reset_n,
	input  stream_beat_t sink_beat_i,
	input  logic         sink_valid_i,
	output logic         sink_ready_o,
	output stream_beat_t source_beat_o,
	output logic         source_valid_o,
	input  logic         source_ready_i,
	input  apb_req_t     apb_req_i,
	output apb_rsp_t     apb_rsp_o
);

	stream_beat_t      in_beat, mix_beat;
	logic              in_valid, out_ready, fire;
	coord_t            pixel_x;
	logic              is_video, frame_done, overlay_en;
	colour_e           colour;
	box_set_t          boxes;
	pixel_t [BLUE:RED] box_col;

	assign fire = in_valid & out_ready;  // beat moves from in_stage to out_stage

	//////////////////////////////////////////////////////////////////////
	// stream path

	stream_reg in_stage (
		.clk, .reset_n,
		.valid_i(sink_valid_i), .data_i(sink_beat_i), .ready_o(sink_ready_o),
		.valid_o(in_valid), .data_o(in_beat), .ready_i(out_ready)
	);

	frame_tracker #(.IMAGE_W(IMAGE_W)) i_frame_tracker (
		.clk, .reset_n, .fire_i(fire), .beat_i(in_beat),
		.pixel_x_o(pixel_x), .is_video_o(is_video)
	);

	colour_classifier #(.RUN_LEN(RUN_LEN)) i_colour_classifier (
		.clk, .reset_n, .fire_i(fire), .beat_i(in_beat), .colour_o(colour)
	);

	box_tracker #(.IMAGE_W(IMAGE_W)) i_box_tracker (
		.clk, .reset_n, .fire_i(fire), .beat_i(in_beat),
		.pixel_x_i(pixel_x), .is_video_i(is_video), .colour_i(colour),
		.boxes_o(boxes), .frame_done_o(frame_done)
	);

	overlay_mixer i_overlay_mixer (
		.beat_i(in_beat), .pixel_x_i(pixel_x), .is_video_i(is_video),
		.colour_i(colour), .boxes_i(boxes), .overlay_en_i(overlay_en),
		.box_col_i(box_col), .beat_o(mix_beat)
	);

	stream_reg out_stage (
		.clk, .reset_n,
		.valid_i(in_valid), .data_i(mix_beat), .ready_o(out_ready),
		.valid_o(source_valid_o), .data_o(source_beat_o), .ready_i(source_ready_i)
	);

	//////////////////////////////////////////////////////////////////////
	// control registers

	apb_regs i_apb_regs (
		.clk, .reset_n,
		.apb_req_i, .apb_rsp_o,
		.boxes_i(boxes), .frame_done_i(frame_done),
		.overlay_en_o(overlay_en), .box_col_o(box_col)
	);

endmodule

`default_nettype wire

// File: dv/tb_imgproc.sv
`default_nettype none

module tb_imgproc
	import video_pkg::*, regs_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int IMAGE_W = 16;
	localparam int RUN_LEN = 5;
	localparam int TIMEOUT = 2000;  // cycles per wait loop
	localparam logic [31:0] SEED = 32'h8ab3_f5f2;

	logic         clk = 1'b0;
	logic         reset_n;
	stream_beat_t sink_beat_i, source_beat_o;
	logic         sink_valid_i, sink_ready_o, source_valid_o, source_ready_i;
	apb_req_t     apb_req_i;
	apb_rsp_t     apb_rsp_o;

	// reference model state
	stream_beat_t exp_q[$];
	pixel_t       frame_q[$];
	logic         ovl_en_ref, video_ref, bp_en;
	logic [23:0]  col_ref [3];        // in red, green, blue order
	logic         box_valid [3];
	int           box_left [3], box_right [3];
	logic         run_hit [3];
	int           run_min [3], run_max [3];
	int           x_ref, run_cnt, frames_ref;
	colour_e      prev_raw;
	logic [31:0]  pix_lfsr = SEED;
	logic [31:0]  rdy_lfsr = SEED;

	always #20 clk = ~clk;

	imgproc_top #(.IMAGE_W(IMAGE_W), .RUN_LEN(RUN_LEN)) i_imgproc_top (
		.clk, .reset_n,
		.sink_beat_i, .sink_valid_i, .sink_ready_o,
		.source_beat_o, .source_valid_o, .source_ready_i,
		.apb_req_i, .apb_rsp_o
	);

	//////////////////////////////////////////////////////////////////////
	// failure reporting and random bits

	task automatic end_with_failure();
		$display("SIMULATION FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERR %0t %s got 0x%08h expected 0x%08h", $time, name, got, exp);
			end_with_failure();
		end
	endtask

	task automatic wait_failed(input string what);
		$display("timed out after %0d cycles waiting for %s", TIMEOUT, what);
		end_with_failure();
	endtask

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			pix_lfsr = lfsr_step(pix_lfsr);
			v = {v[30:0], pix_lfsr[0]};  // one step per bit
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// reference model

	function automatic colour_e raw_colour(pixel_t p);
		int r, g, b;
		r = int'(p.red);
		g = int'(p.green);
		b = int'(p.blue);
		if (r > g + 30 && r > b + 30) return RED;
		if (g > b + 10 && g > r + 30) return GREEN;
		if (b + 20 > g && b > r) return BLUE;
		return NONE;
	endfunction

	function automatic stream_beat_t expected_beat(stream_beat_t b, int x, colour_e filt);
		stream_beat_t e;
		int           sel, grey;
		e = b;
		if (!ovl_en_ref || b.sop || !video_ref) return e;  // pass-through
		sel = -1;
		for (int c = 0; c < 3; c++) begin
			if (sel < 0 && box_valid[c] && (box_left[c] == x || box_right[c] == x)) sel = c;
		end
		grey = int'(b.data.pix.green) / 2 + int'(b.data.pix.red) / 4 + int'(b.data.pix.blue) / 4;
		if (sel >= 0) begin
			e.data.pix = col_ref[sel];
		end else begin
			case (filt)
				RED:     e.data.pix = 24'hFF0000;
				GREEN:   e.data.pix = 24'h00FF00;
				BLUE:    e.data.pix = 24'h0000FF;
				default: e.data.pix = {3{8'(grey)}};
			endcase
		end
		return e;
	endfunction

	task automatic clear_running();
		for (int c = 0; c < 3; c++) begin
			run_hit[c] = 1'b0;
			run_min[c] = IMAGE_W - 1;
			run_max[c] = 0;
		end
	endtask

	// advances the model by one input beat and queues the expected output
	task automatic model_beat(input stream_beat_t b);
		colour_e raw, filt;
		int      same, c;
		if (b.sop) begin
			video_ref = (b.data.desc.packet_type == 4'h0);
			x_ref     = 0;
			prev_raw  = NONE;
			run_cnt   = 0;
			clear_running();
			exp_q.push_back(b);
		end else begin
			raw  = raw_colour(b.data.pix);
			same = (raw == prev_raw) ? run_cnt : 0;  // earlier pixels matching this one
			filt = (same >= RUN_LEN) ? raw : NONE;
			exp_q.push_back(expected_beat(b, x_ref, filt));
			if (filt != NONE) begin
				c = int'(filt) - 1;
				run_hit[c] = 1'b1;
				if (x_ref < run_min[c]) run_min[c] = x_ref;
				if (x_ref > run_max[c]) run_max[c] = x_ref;
			end
			if (b.eop && video_ref) begin  // frame end latches boxes
				for (int k = 0; k < 3; k++) begin
					box_valid[k] = run_hit[k];
					box_left[k]  = run_min[k];
					box_right[k] = run_max[k];
				end
				frames_ref++;
				clear_running();
			end
			prev_raw = raw;
			run_cnt  = same + 1;
			x_ref    = (x_ref + 1) % IMAGE_W;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// stream and APB drivers

	task automatic send_beat(input stream_beat_t b);
		int waited;
		@(negedge clk);
		sink_beat_i  = b;
		sink_valid_i = 1'b1;
		waited = 0;
		@(posedge clk);
		while (!sink_ready_o) begin
			waited++;
			if (waited > TIMEOUT) wait_failed("the sink to accept a beat");
			@(posedge clk);
		end
	endtask

	task automatic send_packet(input logic [3:0] ptype);
		stream_beat_t b;
		b = '0;
		b.sop = 1'b1;
		b.data.desc.reserved    = 20'h5a5a5;
		b.data.desc.packet_type = ptype;
		model_beat(b);
		send_beat(b);
		for (int i = 0; i < frame_q.size(); i++) begin
			b = '0;
			b.data.pix = frame_q[i];
			b.eop = (i == frame_q.size() - 1);
			model_beat(b);
			send_beat(b);
		end
		@(negedge clk);
		sink_valid_i = 1'b0;
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		@(negedge clk);
		while (exp_q.size() != 0) begin
			waited++;
			if (waited > TIMEOUT) wait_failed("the source to deliver all expected beats");
			@(negedge clk);
		end
		@(posedge clk);
	endtask

	task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
			output logic [31:0] rdata, output logic err);
		int waited;
		@(negedge clk);
		apb_req_i = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
		@(negedge clk);
		apb_req_i.penable = 1'b1;  // access phase
		waited = 0;
		@(posedge clk);
		while (!apb_rsp_o.pready) begin
			waited++;
			if (waited > TIMEOUT) wait_failed("pready");
			@(posedge clk);
		end
		rdata = apb_rsp_o.prdata;
		err   = apb_rsp_o.pslverr;
		@(negedge clk);
		apb_req_i = '0;
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] rdata);
		logic err;
		apb_access(1'b0, addr, 32'h0, rdata, err);
		check_value("pslverr", {31'b0, err}, 32'd0);
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] wdata);
		logic [31:0] rdata;
		logic        err;
		apb_access(1'b1, addr, wdata, rdata, err);
		check_value("pslverr", {31'b0, err}, 32'd0);
	endtask

	task automatic set_overlay(input logic en);
		apb_write(ADDR_CTRL, {31'b0, en});
		ovl_en_ref = en;
	endtask

	task automatic check_boxes();
		logic [31:0] rd, exp;
		for (int k = 0; k < 3; k++) begin
			apb_read(ADDR_BOX_RED + 8'(4 * k), rd);
			exp = {box_valid[k], 4'b0, 11'(box_left[k]), 5'b0, 11'(box_right[k])};
			check_value("box readback", rd, exp);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// frame builders

	function automatic pixel_t shape_pixel(logic [1:0] kind, logic [23:0] rnd);
		pixel_t p;
		p = rnd;
		case (kind)
			2'd1: begin
				p.red[7:6]   = 2'b11;
				p.green[7:6] = 2'b00;
				p.blue[7:6]  = 2'b00;
			end
			2'd2: begin
				p.red[7:6]   = 2'b00;
				p.green[7:6] = 2'b11;
				p.blue[7:6]  = 2'b00;
			end
			2'd3: begin
				p.red[7:6]   = 2'b00;
				p.green[7:6] = 2'b00;
				p.blue[7:6]  = 2'b11;
			end
			default: ;  // fully random pixel
		endcase
		return p;
	endfunction

	// runs of 1 to 8 pixels so that some stay shorter than the filter
	task automatic build_random_frame(input int n_pix);
		logic [31:0] kind, len, rnd;
		frame_q.delete();
		while (frame_q.size() < n_pix) begin
			rand_bits(2, kind);
			rand_bits(3, len);
			for (int i = 0; i <= int'(len) && frame_q.size() < n_pix; i++) begin
				rand_bits(24, rnd);
				frame_q.push_back(shape_pixel(kind[1:0], rnd[23:0]));
			end
		end
	endtask

	task automatic build_directed_frame(input logic with_runs);
		pixel_t p;
		frame_q.delete();
		for (int i = 0; i < 3 * IMAGE_W; i++) begin
			p = 24'h404040;                                      // no colour class
			if (with_runs && i >= 3 && i <= 11) p = 24'hE01010;  // red in row 0
			if (with_runs && i >= 17 && i <= 29) p = 24'h1010E0; // blue in row 1
			frame_q.push_back(p);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// back-pressure and output comparison

	initial begin
		source_ready_i = 1'b1;
		forever begin
			@(negedge clk);
			if (bp_en) begin
				rdy_lfsr = lfsr_step(rdy_lfsr);
				source_ready_i = rdy_lfsr[0];
			end else begin
				source_ready_i = 1'b1;
			end
		end
	end

	always @(posedge clk) begin
		if (reset_n && source_valid_o && source_ready_i) begin
			if (exp_q.size() == 0) begin
				$display("output beat 0x%07h arrived with none expected", source_beat_o);
				end_with_failure();
			end else begin
				check_value("source_beat_o", {6'b0, source_beat_o}, {6'b0, exp_q.pop_front()});
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// test sequence

	initial begin
		logic [31:0] rd;
		logic        err;
		sink_valid_i = 1'b0;
		sink_beat_i  = '0;
		apb_req_i    = '0;
		bp_en        = 1'b0;
		reset_n      = 1'b0;
		ovl_en_ref   = 1'b0;
		video_ref    = 1'b0;
		col_ref      = '{24'hFF0000, 24'h00FF00, 24'h0000FF};
		for (int k = 0; k < 3; k++) begin
			box_valid[k] = 1'b0;
			box_left[k]  = 0;
			box_right[k] = 0;
		end
		x_ref      = 0;
		run_cnt    = 0;
		prev_raw   = NONE;
		frames_ref = 0;
		clear_running();
		repeat (8) @(negedge clk);
		reset_n = 1'b1;
		@(negedge clk);
		check_value("sink_ready_o", {31'b0, sink_ready_o}, 32'd1);
		check_value("source_valid_o", {31'b0, source_valid_o}, 32'd0);

		// register map after reset
		apb_read(ADDR_ID, rd);
		check_value("ID", rd, 32'h1234EEE2);
		for (int k = 0; k < 3; k++) begin
			apb_read(ADDR_COL_RED + 8'(4 * k), rd);
			check_value("box colour", rd, {8'b0, col_ref[k]});
		end
		apb_write(ADDR_COL_RED, 32'h00C0_3090);
		col_ref[0] = 24'hC03090;
		apb_read(ADDR_COL_RED, rd);
		check_value("COL_RED", rd, 32'h00C0_3090);
		apb_access(1'b0, 8'h40, 32'h0, rd, err);  // unlisted offset
		check_value("pslverr", {31'b0, err}, 32'd1);
		apb_access(1'b1, ADDR_ID, 32'hDEAD_BEEF, rd, err);
		check_value("pslverr", {31'b0, err}, 32'd1);
		apb_read(ADDR_ID, rd);
		check_value("ID", rd, 32'h1234EEE2);

		// overlay off
		repeat (2) begin
			build_random_frame(3 * IMAGE_W);
			send_packet(4'h0);
		end
		wait_drain();

		// non-video packet with the overlay on
		set_overlay(1'b1);
		build_random_frame(20);
		send_packet(4'h3);
		wait_drain();

		repeat (3) begin
			build_random_frame(3 * IMAGE_W);
			send_packet(4'h0);
		end
		wait_drain();

		// red and blue runs then a flat frame that shows the columns
		build_directed_frame(1'b1);
		send_packet(4'h0);
		wait_drain();
		check_boxes();
		apb_read(ADDR_STATUS, rd);
		check_value("STATUS", rd, {16'b0, 16'(frames_ref)});
		build_directed_frame(1'b0);
		send_packet(4'h0);
		wait_drain();

		// random source back-pressure
		bp_en = 1'b1;
		repeat (4) begin
			build_random_frame(3 * IMAGE_W);
			send_packet(4'h0);
		end
		build_random_frame(10);
		send_packet(4'h3);
		wait_drain();

		// idle with the source ready so a duplicated beat would still surface
		bp_en = 1'b0;
		repeat (4) @(negedge clk);
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
design/video_pkg.sv
design/regs_pkg.sv
design/stream_reg.sv
design/frame_tracker.sv
design/colour_classifier.sv
design/box_tracker.sv
design/overlay_mixer.sv
design/apb_regs.sv
design/imgproc_top.sv
dv/tb_imgproc.sv

// File: Makefile
TOOL  = verilator
FLAGS = --binary --timing -j 0
TOP   = tb_imgproc
FLIST = flist.f
OBJ   = obj_dir
LOG   = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ) -f $(FLIST)

run: compile
	./$(OBJ)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG) || (echo "simulation ended without result"; exit 1)

clean:
	rm -rf $(OBJ) $(LOG)
